/* compile.f */
source/lsu_pkg.sv
source/agu_stage.sv
source/load_store_unit.sv
source/wb_access_stage.sv
source/data_ram.sv
source/lsu_subsystem.sv
dv/lsu_subsystem_tb.sv

/* dv/lsu_subsystem_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lsu subsystem testbench
// replays an access trace and checks every response in request order.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module lsu_subsystem_tb;

    localparam int MAX_LINES      = 64;
    localparam int TIMEOUT_CYCLES = 100;
    localparam int BURST_LINES    = 6;

    logic             clk;
    logic             rst_n;
    logic             req_valid;
    logic             req_ready;
    logic             req_store;
    lsu_pkg::funct3_t req_funct3;
    lsu_pkg::word_t   req_base;
    lsu_pkg::word_t   req_offset;
    lsu_pkg::word_t   req_store_data;
    logic             rsp_valid;
    logic             rsp_fault;
    lsu_pkg::word_t   rsp_load_data;

    // trace contents, one entry per access.
    logic             t_store [MAX_LINES];
    lsu_pkg::funct3_t t_funct3 [MAX_LINES];
    lsu_pkg::word_t   t_base [MAX_LINES];
    lsu_pkg::word_t   t_offset [MAX_LINES];
    lsu_pkg::word_t   t_store_data [MAX_LINES];
    logic             t_fault [MAX_LINES];
    lsu_pkg::word_t   t_load_data [MAX_LINES];
    int               n_lines;

    // accepted requests still waiting for their response.
    int               pending_q [$];

    int               mismatches;
    int               timeouts;
    int               other_errors;
    int               rsp_count;

    lsu_subsystem #(
        .RAM_ADDR_BITS(8),
        .WAIT_CYCLES(2)
    ) DUT (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_store(req_store),
        .req_funct3(req_funct3), .req_base(req_base), .req_offset(req_offset),
        .req_store_data(req_store_data),
        .rsp_valid(rsp_valid), .rsp_fault(rsp_fault), .rsp_load_data(rsp_load_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic read_trace();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_store;
        logic [31:0] f_funct3;
        logic [31:0] f_base;
        logic [31:0] f_offset;
        logic [31:0] f_store_data;
        logic [31:0] f_fault;
        logic [31:0] f_load_data;
        fd = $fopen("dv/lsu_trace.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("ERROR: trace file dv/lsu_trace.txt could not be opened");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0) begin
                break;
            end
            // blank lines and column notes.
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h", f_store, f_funct3, f_base,
                        f_offset, f_store_data, f_fault, f_load_data);
            if (n != 7 || n_lines >= MAX_LINES) begin
                other_errors++;
                $display("ERROR: trace line could not be used: %s", line);
            end else begin
                t_store[n_lines]      = f_store[0];
                t_funct3[n_lines]     = f_funct3[2:0];
                t_base[n_lines]       = f_base;
                t_offset[n_lines]     = f_offset;
                t_store_data[n_lines] = f_store_data;
                t_fault[n_lines]      = f_fault[0];
                t_load_data[n_lines]  = f_load_data;
                n_lines++;
            end
        end
        $fclose(fd);
        if (n_lines == 0) begin
            other_errors++;
            $display("ERROR: trace file holds no accesses");
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer.
    task automatic send_request(input int idx);
        int waited;
        req_valid      = 1'b1;
        req_store      = t_store[idx];
        req_funct3     = t_funct3[idx];
        req_base       = t_base[idx];
        req_offset     = t_offset[idx];
        req_store_data = t_store_data[idx];
        waited = 0;
        while (!req_ready && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            timeouts++;
            $display("TIMEOUT at %0t: request for trace line %0d was never accepted", $time, idx);
        end else begin
            pending_q.push_back(idx);
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drive_trace();
        int gap;
        for (int i = 0; i < n_lines; i++) begin
            send_request(i);
            // the tail of the trace goes back to back.
            gap = (i >= n_lines - BURST_LINES) ? 0 : int'($urandom % 4);
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic check_responses();
        int waited;
        int idx;
        for (int i = 0; i < n_lines; i++) begin
            waited = 0;
            @(negedge clk);
            while (!rsp_valid && waited < TIMEOUT_CYCLES) begin
                @(negedge clk);
                waited++;
            end
            if (!rsp_valid) begin
                timeouts++;
                $display("TIMEOUT at %0t: response %0d did not arrive", $time, i);
                break;
            end
            rsp_count++;
            if (pending_q.size() == 0) begin
                other_errors++;
                $display("ERROR at %0t: a response arrived with no request outstanding", $time);
            end else begin
                idx = pending_q.pop_front();
                if (rsp_fault !== t_fault[idx]) begin
                    mismatches++;
                    $display("MISMATCH at %0t: rsp_fault expected %0b actual %0b (line %0d)",
                             $time, t_fault[idx], rsp_fault, idx);
                end
                if (rsp_load_data !== t_load_data[idx]) begin
                    mismatches++;
                    $display("MISMATCH at %0t: rsp_load_data expected %h actual %h (line %0d)",
                             $time, t_load_data[idx], rsp_load_data, idx);
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'hc7de580d));
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req_store      = 1'b0;
        req_funct3     = '0;
        req_base       = '0;
        req_offset     = '0;
        req_store_data = '0;
        n_lines        = 0;
        mismatches     = 0;
        timeouts       = 0;
        other_errors   = 0;
        rsp_count      = 0;
        read_trace();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        // idle state out of reset.
        if (req_ready !== 1'b1) begin
            mismatches++;
            $display("MISMATCH at %0t: req_ready expected 1 actual %b", $time, req_ready);
        end
        if (rsp_valid !== 1'b0) begin
            mismatches++;
            $display("MISMATCH at %0t: rsp_valid expected 0 actual %b", $time, rsp_valid);
        end
        fork
            drive_trace();
            check_responses();
        join
        if (rsp_count != n_lines) begin
            other_errors++;
            $display("ERROR: %0d trace accesses but %0d responses counted", n_lines, rsp_count);
        end
        $display("done: %0d mismatches, %0d timeouts, %0d other errors",
                 mismatches, timeouts, other_errors);
        if (mismatches == 0 && timeouts == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* dv/lsu_trace.txt */
# columns, all hex: store funct3 base offset store_data expected_fault expected_load_data
# the last six accesses are issued back to back with no idle cycles
1 2 00000100 00000000 12345678 0 00000000
0 2 00000100 00000000 00000000 0 12345678
1 1 00000100 00000002 0000beef 0 00000000
0 1 00000102 00000000 00000000 0 ffffbeef
0 5 00000100 00000002 00000000 0 0000beef
1 2 00000200 00000000 11223344 0 00000000
1 0 00000200 00000001 ffffff82 0 00000000
0 2 00000200 00000000 00000000 0 11228244
1 0 00000200 00000000 000000a1 0 00000000
1 0 00000200 00000002 000000c3 0 00000000
1 0 00000200 00000003 00000074 0 00000000
0 2 00000200 00000000 00000000 0 74c382a1
0 0 00000200 00000001 00000000 0 ffffff82
0 4 00000200 00000001 00000000 0 00000082
0 1 00000200 00000000 00000000 0 ffff82a1
0 5 00000200 00000000 00000000 0 000082a1
0 2 00000210 fffffff0 00000000 0 74c382a1
0 1 00000200 00000001 00000000 1 00000000
1 2 00000100 00000002 deadbeef 1 00000000
0 3 00000100 00000000 00000000 1 00000000
1 7 00000200 00000000 ffffffff 1 00000000
1 4 00000200 00000000 000000ff 1 00000000
1 5 00000200 00000002 0000ffff 1 00000000
0 2 00000100 00000000 00000000 0 beef5678
0 2 00000200 00000000 00000000 0 74c382a1
1 2 00000300 00000000 cafef00d 0 00000000
0 2 00000300 00000000 00000000 0 cafef00d
1 0 00000300 00000001 00000055 0 00000000
0 4 00000300 00000001 00000000 0 00000055
0 2 00000300 00000001 00000000 1 00000000
0 2 00000300 00000000 00000000 0 cafe550d

/* run_sim.sh */
#!/bin/sh
# build and run the lsu testbench with verilator, then scan the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal -f compile.f --top-module lsu_subsystem_tb \
    -o lsu_sim > sim.log 2>&1 \
    && ./obj_dir/lsu_sim >> sim.log 2>&1 \
    || { echo "build or simulation error, see sim.log"; exit 1; }
grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"

/* source/agu_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address generation stage
// adds base and offset, flags bad accesses and holds one request.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module agu_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  logic              req_store,
    input  lsu_pkg::funct3_t  req_funct3,
    input  lsu_pkg::word_t    req_base,
    input  lsu_pkg::word_t    req_offset,
    input  lsu_pkg::word_t    req_store_data,
    output logic              s1_valid,
    input  logic              s1_ready,
    output logic              s1_store,
    output lsu_pkg::funct3_t  s1_funct3,
    output lsu_pkg::word_t    s1_addr,
    output lsu_pkg::word_t    s1_store_data,
    output logic              s1_fault
);

    lsu_pkg::word_t eff_addr;
    logic           fault;

    assign eff_addr = req_base + req_offset;

    // empty, or the held item leaves this cycle.
    assign req_ready = !s1_valid || s1_ready;

    always_comb begin
        case (req_funct3)
            lsu_pkg::FUNCT3_LB_SB: fault = 1'b0;
            lsu_pkg::FUNCT3_LH_SH: fault = eff_addr[0];
            lsu_pkg::FUNCT3_LW_SW: fault = eff_addr[1:0] != 2'b00;
            lsu_pkg::FUNCT3_LBU:   fault = req_store;
            lsu_pkg::FUNCT3_LHU:   fault = req_store || eff_addr[0];
            default:               fault = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (req_ready) begin
            s1_valid <= req_valid;
        end
    end

    // request payload.
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            s1_store      <= req_store;
            s1_funct3     <= req_funct3;
            s1_addr       <= eff_addr;
            s1_store_data <= req_store_data;
            s1_fault      <= fault;
        end
    end

    // a stalled request must hold its fields.
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req_store)
            && $stable(req_funct3) && $stable(req_base) && $stable(req_offset)
            && $stable(req_store_data));

endmodule

/* source/data_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data ram
// word-wide wishbone classic slave with byte selects and wait states.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module data_ram #(
    parameter int RAM_ADDR_BITS = 8,
    parameter int WAIT_CYCLES   = 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  lsu_pkg::word_t    wb_adr,
    input  lsu_pkg::wstrobe_t wb_sel,
    input  lsu_pkg::word_t    wb_dat_mosi,
    output logic              wb_ack,
    output lsu_pkg::word_t    wb_dat_miso
);

    localparam int DEPTH    = 1 << RAM_ADDR_BITS;
    localparam int CNT_BITS = $clog2(WAIT_CYCLES + 2);

    typedef logic [CNT_BITS-1:0] wait_cnt_t;

    localparam wait_cnt_t LAST_WAIT = wait_cnt_t'(WAIT_CYCLES);

    lsu_pkg::word_t           mem [DEPTH];
    logic [RAM_ADDR_BITS-1:0] index;
    wait_cnt_t                wait_cnt;
    logic                     access;

    assign index = wb_adr[RAM_ADDR_BITS-1:0];

    // last wait cycle of a live strobe.
    assign access = wb_cyc && wb_stb && !wb_ack && (wait_cnt == LAST_WAIT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wait_cnt <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            wb_ack <= access;
            if (!(wb_cyc && wb_stb) || wb_ack || access) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (access && wb_we) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (wb_sel[lane]) begin
                        mem[index][8 * lane +: 8] <= wb_dat_mosi[8 * lane +: 8];
                    end
                end
            end
        end
    end

    // read word lines up with ack.
    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_miso <= mem[index];
        end
    end

    a_ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_stb);

endmodule

/* source/load_store_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store formatter
// builds write strobes and lane data, extracts and extends load data.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module load_store_unit (
    input  lsu_pkg::funct3_t  funct3,
    input  lsu_pkg::word_t    address,
    input  logic              store_enable,
    input  lsu_pkg::word_t    store_data,
    output lsu_pkg::wstrobe_t wstrobe,
    output lsu_pkg::word_t    wdata,
    input  lsu_pkg::word_t    rdata,
    output lsu_pkg::word_t    load_data
);

    logic [2:0]  size;
    logic [1:0]  align;
    logic [15:0] rdata_half;
    logic [7:0]  rdata_byte;

    assign align = address[1:0];

    // access size in bytes, store data copied to every lane it may hit.
    always_comb begin
        case (funct3)
            lsu_pkg::FUNCT3_LB_SB, lsu_pkg::FUNCT3_LBU: begin
                size  = 3'd1;
                wdata = {4{store_data[7:0]}};
            end
            lsu_pkg::FUNCT3_LH_SH, lsu_pkg::FUNCT3_LHU: begin
                size  = 3'd2;
                wdata = {2{store_data[15:0]}};
            end
            lsu_pkg::FUNCT3_LW_SW: begin
                size  = 3'd4;
                wdata = store_data;
            end
            default: begin
                size  = 3'd0;
                wdata = store_data;
            end
        endcase
    end

    // lanes align through align + size - 1.
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            wstrobe[i] = store_enable && (i >= align) && (i < align + size);
        end
    end

    assign rdata_half = align[1] ? rdata[31:16] : rdata[15:0];
    assign rdata_byte = rdata[8 * align +: 8];

    always_comb begin
        case (funct3)
            lsu_pkg::FUNCT3_LB_SB: load_data = {{24{rdata_byte[7]}}, rdata_byte};
            lsu_pkg::FUNCT3_LBU:   load_data = {24'd0, rdata_byte};
            lsu_pkg::FUNCT3_LH_SH: load_data = {{16{rdata_half[15]}}, rdata_half};
            lsu_pkg::FUNCT3_LHU:   load_data = {16'd0, rdata_half};
            default:               load_data = rdata;
        endcase
    end

endmodule

/* source/lsu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lsu package
// shared word, strobe and funct3 types plus the bus state encoding.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package lsu_pkg;

    // data or address word.
    typedef logic [31:0] word_t;

    // one enable bit per byte lane.
    typedef logic [3:0] wstrobe_t;

    // risc-v load/store width code.
    typedef logic [2:0] funct3_t;

    // width codes shared by loads and stores.
    localparam funct3_t FUNCT3_LB_SB = 3'd0;
    localparam funct3_t FUNCT3_LH_SH = 3'd1;
    localparam funct3_t FUNCT3_LW_SW = 3'd2;

    // unsigned variants, legal for loads only.
    localparam funct3_t FUNCT3_LBU = 3'd4;
    localparam funct3_t FUNCT3_LHU = 3'd5;

    // codes 3, 6 and 7 are left undefined and fault.

    // stage 2 bus sequencing.
    typedef enum logic [1:0] {
        IDLE,
        BUS,
        RESP
    } wb_state_t;

endpackage

/* source/lsu_subsystem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lsu subsystem
// address stage, formatter, wishbone stage and data ram in one block.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module lsu_subsystem #(
    parameter int RAM_ADDR_BITS = 8,
    parameter int WAIT_CYCLES   = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    output logic             req_ready,
    input  logic             req_store,
    input  lsu_pkg::funct3_t req_funct3,
    input  lsu_pkg::word_t   req_base,
    input  lsu_pkg::word_t   req_offset,
    input  lsu_pkg::word_t   req_store_data,
    output logic             rsp_valid,
    output logic             rsp_fault,
    output lsu_pkg::word_t   rsp_load_data
);

    logic              s1_valid;
    logic              s1_ready;
    logic              s1_store;
    lsu_pkg::funct3_t  s1_funct3;
    lsu_pkg::word_t    s1_addr;
    lsu_pkg::word_t    s1_store_data;
    logic              s1_fault;
    lsu_pkg::wstrobe_t wstrobe;
    lsu_pkg::word_t    wdata;
    lsu_pkg::word_t    load_data;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    lsu_pkg::word_t    wb_adr;
    lsu_pkg::wstrobe_t wb_sel;
    lsu_pkg::word_t    wb_dat_mosi;
    logic              wb_ack;
    lsu_pkg::word_t    wb_dat_miso;

    agu_stage u_agu (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_store(req_store),
        .req_funct3(req_funct3), .req_base(req_base), .req_offset(req_offset),
        .req_store_data(req_store_data),
        .s1_valid(s1_valid), .s1_ready(s1_ready), .s1_store(s1_store),
        .s1_funct3(s1_funct3), .s1_addr(s1_addr), .s1_store_data(s1_store_data),
        .s1_fault(s1_fault)
    );

    // faulting stores never reach the strobes.
    load_store_unit u_fmt (
        .funct3(s1_funct3), .address(s1_addr),
        .store_enable(s1_valid && s1_store && !s1_fault),
        .store_data(s1_store_data), .wstrobe(wstrobe), .wdata(wdata),
        .rdata(wb_dat_miso), .load_data(load_data)
    );

    wb_access_stage u_wb (
        .clk(clk), .rst_n(rst_n),
        .s1_valid(s1_valid), .s1_ready(s1_ready), .s1_store(s1_store),
        .s1_addr(s1_addr), .s1_fault(s1_fault),
        .wstrobe(wstrobe), .wdata(wdata), .load_data(load_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_mosi(wb_dat_mosi), .wb_ack(wb_ack),
        .rsp_valid(rsp_valid), .rsp_fault(rsp_fault), .rsp_load_data(rsp_load_data)
    );

    data_ram #(
        .RAM_ADDR_BITS(RAM_ADDR_BITS),
        .WAIT_CYCLES(WAIT_CYCLES)
    ) u_ram (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_mosi(wb_dat_mosi),
        .wb_ack(wb_ack), .wb_dat_miso(wb_dat_miso)
    );

endmodule

/* source/wb_access_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone access stage
// runs one classic bus cycle per request and returns the response.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module wb_access_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              s1_valid,
    output logic              s1_ready,
    input  logic              s1_store,
    input  lsu_pkg::word_t    s1_addr,
    input  logic              s1_fault,
    input  lsu_pkg::wstrobe_t wstrobe,
    input  lsu_pkg::word_t    wdata,
    input  lsu_pkg::word_t    load_data,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output lsu_pkg::word_t    wb_adr,
    output lsu_pkg::wstrobe_t wb_sel,
    output lsu_pkg::word_t    wb_dat_mosi,
    input  logic              wb_ack,
    output logic              rsp_valid,
    output logic              rsp_fault,
    output lsu_pkg::word_t    rsp_load_data
);

    lsu_pkg::wb_state_t state;
    lsu_pkg::wb_state_t state_next;
    logic               bus_done;

    // the item stays in stage 1 until the bus cycle ends,
    // so the formatter keeps seeing it.
    assign bus_done = (state == lsu_pkg::BUS) && wb_ack;
    assign s1_ready = bus_done || (state == lsu_pkg::RESP);

    always_comb begin
        state_next = state;
        case (state)
            lsu_pkg::IDLE: begin
                if (s1_valid) begin
                    state_next = s1_fault ? lsu_pkg::RESP : lsu_pkg::BUS;
                end
            end
            lsu_pkg::BUS: begin
                if (wb_ack) begin
                    state_next = lsu_pkg::IDLE;
                end
            end
            // fault response, no bus cycle.
            lsu_pkg::RESP: state_next = lsu_pkg::IDLE;
            default: state_next = lsu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= lsu_pkg::IDLE;
            rsp_valid <= 1'b0;
        end else begin
            state     <= state_next;
            rsp_valid <= s1_ready;
        end
    end

    // response payload.
    always_ff @(posedge clk) begin
        if (bus_done) begin
            rsp_fault     <= 1'b0;
            rsp_load_data <= s1_store ? '0 : load_data;
        end else if (state == lsu_pkg::RESP) begin
            rsp_fault     <= 1'b1;
            rsp_load_data <= '0;
        end
    end

    // cyc and stb move together.
    assign wb_cyc      = (state == lsu_pkg::BUS);
    assign wb_stb      = (state == lsu_pkg::BUS);
    assign wb_we       = (state == lsu_pkg::BUS) && s1_store;
    assign wb_adr      = {2'b00, s1_addr[31:2]};
    assign wb_sel      = s1_store ? wstrobe : 4'hf;
    assign wb_dat_mosi = wdata;

    // the bus cycle serves a held, legal item.
    a_bus_item_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc |-> s1_valid && !s1_fault);

    // a legal store always touches a lane.
    a_write_has_sel: assert property (@(posedge clk) disable iff (!rst_n)
        wb_we |-> wb_sel != 4'h0);

endmodule
